//--- hub_motor_settings.svh
`ifndef HUB_MOTOR_SETTINGS_SVH
`define HUB_MOTOR_SETTINGS_SVH

////////////////////
// pwm measurement
////////////////////

// width of period and on-time counters, one period is 2048 clk
`define PWM_BITS 11

// a coil end with both duties below this is floating
`define DUTY_DRIVEN 11'h3FF

////////////////////
// mechanics
////////////////////

// friction torque magnitude
`define FRICTION 13'h070

// one revolution, 360 deg * 64
`define THETA_FULL 15'd23040

// 30 deg * 64, middle of green rise sector
`define THETA_RESET 15'd1920

// below this speed friction adds nothing
`define OMEGA_DEADBAND 20'h00200

`endif

//--- motor_pkg.sv
`include "hub_motor_settings.svh"

package motor_pkg;

  ////////////////////
  // gate side
  ////////////////////

  typedef logic [`PWM_BITS-1:0] duty_t;  // on-time in clk per pwm period

  // six fet gate levels, grn/ylw/blu coil ends
  typedef struct packed {
    logic high_grn;
    logic low_grn;
    logic high_ylw;
    logic low_ylw;
    logic high_blu;
    logic low_blu;
  } gate_drive_t;

  // captured on-times, same field order as gate_drive_t
  typedef struct packed {
    duty_t high_grn;
    duty_t low_grn;
    duty_t high_ylw;
    duty_t low_ylw;
    duty_t high_blu;
    duty_t low_blu;
  } duty_set_t;

  ////////////////////
  // coil side
  ////////////////////

  typedef logic signed [12:0] coil_v_t;  // +/-4094 full scale

  typedef struct packed {
    coil_v_t gy;  // green to yellow
    coil_v_t yb;  // yellow to blue
    coil_v_t bg;  // blue to green
  } coil_set_t;

  typedef logic [11:0] curr_t;  // filtered average current

endpackage

//--- rotor_pkg.sv
package rotor_pkg;

  ////////////////////
  // rotor state types
  ////////////////////

  typedef logic signed [12:0] torque_t;  // torque, also angular accel
  typedef logic signed [19:0] omega_t;   // angular velocity
  typedef logic [14:0]        theta_t;   // angle, deg * 64

  // hall sensor outputs, grn is msb
  typedef struct packed {
    logic grn;
    logic ylw;
    logic blu;
  } hall_t;

  ////////////////////
  // hall sectors, forward order
  ////////////////////

  localparam hall_t HALL_GRN_RISE = 3'b101;  //   0..59 deg
  localparam hall_t HALL_GRN_2ND  = 3'b100;  //  60..119
  localparam hall_t HALL_YLW_RISE = 3'b110;  // 120..179
  localparam hall_t HALL_YLW_2ND  = 3'b010;  // 180..239
  localparam hall_t HALL_BLU_RISE = 3'b011;  // 240..299
  localparam hall_t HALL_BLU_2ND  = 3'b001;  // 300..359

endpackage

//--- duty_capture.sv
`timescale 1ns/100ps

module duty_capture (
  input  logic                   clk,
  input  logic                   RST_n,
  input  motor_pkg::gate_drive_t gates,
  output motor_pkg::duty_set_t   duty,
  output logic                   period_vld
);

  import motor_pkg::*;

  localparam int N_GATES = $bits(gate_drive_t);  // six fets

  duty_t               period_cnt;  // free running with wrap every 2048 clk
  logic                period_end;  // last cycle of the period
  logic [N_GATES-1:0]  gate_vec;    // gates flattened with high_grn at [5]
  duty_t [N_GATES-1:0] on_cnt;      // running on-time per gate
  duty_t [N_GATES-1:0] on_cap;      // on-time of the last full period

  assign gate_vec = gates;

  ////////////////////
  // pwm period counter
  ////////////////////

  always_ff @(posedge clk, negedge RST_n) begin
    if (!RST_n) begin
      period_cnt <= '0;
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  assign period_end = &period_cnt;  // all ones first at 2047 clk after reset

  ////////////////////
  // on-time counters
  ////////////////////

  // count clk with gate high and restart each period
  always_ff @(posedge clk, negedge RST_n) begin
    if (!RST_n) begin
      on_cnt <= '0;
    end else begin
      for (int i = 0; i < N_GATES; i++) begin
        if (period_end) begin
          on_cnt[i] <= '0;
        end else if (gate_vec[i]) begin
          on_cnt[i] <= on_cnt[i] + 1'b1;
        end
      end
    end
  end

  // snapshot at period end
  always_ff @(posedge clk, negedge RST_n) begin
    if (!RST_n) begin
      on_cap <= '0;
    end else if (period_end) begin
      on_cap <= on_cnt;
    end
  end

  // new duty set is valid the cycle after period_end
  always_ff @(posedge clk, negedge RST_n) begin
    if (!RST_n) begin
      period_vld <= 1'b0;
    end else begin
      period_vld <= period_end;
    end
  end

  assign duty = duty_set_t'(on_cap);  // field order matches gate_vec

endmodule

//--- coil_voltage.sv
`timescale 1ns/100ps
`include "hub_motor_settings.svh"

module coil_voltage (
  input  motor_pkg::duty_set_t duty,
  output motor_pkg::coil_set_t coil
);

  import motor_pkg::*;

  localparam duty_t DRIVEN_MIN = duty_t'(`DUTY_DRIVEN);

  // coil end floats when neither fet is on for a good part of the period
  function automatic logic undriven(input duty_t hi, input duty_t lo);
    return (hi < DRIVEN_MIN) && (lo < DRIVEN_MIN);
  endfunction

  // voltage across a coil pair, end a minus end b
  function automatic coil_v_t end_to_end(input duty_t hi_a, lo_a, hi_b, lo_b);
    coil_v_t drive_a;  // net drive of end a
    coil_v_t drive_b;  // net drive of end b
    drive_a = $signed({2'b00, hi_a}) - $signed({2'b00, lo_a});
    drive_b = $signed({2'b00, hi_b}) - $signed({2'b00, lo_b});
    if (undriven(hi_a, lo_a) || undriven(hi_b, lo_b)) begin
      return '0;  // no current path
    end
    return drive_a - drive_b;  // max +/-4094
  endfunction

  ////////////////////
  // line to line voltages
  ////////////////////

  assign coil.gy = end_to_end(duty.high_grn, duty.low_grn,
                              duty.high_ylw, duty.low_ylw);
  assign coil.yb = end_to_end(duty.high_ylw, duty.low_ylw,
                              duty.high_blu, duty.low_blu);
  assign coil.bg = end_to_end(duty.high_blu, duty.low_blu,
                              duty.high_grn, duty.low_grn);

endmodule

//--- torque_model.sv
`timescale 1ns/100ps
`include "hub_motor_settings.svh"

module torque_model (
  input  motor_pkg::coil_set_t coil,
  input  rotor_pkg::hall_t     hall,
  input  rotor_pkg::omega_t    omega,
  output rotor_pkg::torque_t   alpha
);

  import motor_pkg::*;
  import rotor_pkg::*;

  localparam torque_t FRICTION_T = torque_t'(`FRICTION);
  localparam omega_t  DEADBAND   = omega_t'(`OMEGA_DEADBAND);

  coil_v_t gy, yb, bg;  // coil voltages, unpacked for the table
  omega_t  omega_abs;   // speed magnitude
  torque_t back_emf;    // grows with speed, opposes coil drive
  torque_t raw_torque;  // commutated coil voltage less back emf
  torque_t net_torque;  // after friction

  assign gy = coil.gy;
  assign yb = coil.yb;
  assign bg = coil.bg;

  assign omega_abs = omega[19] ? -omega : omega;
  assign back_emf  = torque_t'(omega_abs[17:5]);

  ////////////////////
  // commutation table
  ////////////////////

  always_comb begin
    raw_torque = '0;
    case (hall)
      HALL_GRN_RISE: raw_torque = (gy >= 0) ? gy - back_emf : gy + back_emf;
      HALL_GRN_2ND: begin
        if (bg <= 0) raw_torque = -bg - back_emf;
        else if (yb > 0) raw_torque = -yb + back_emf;
      end
      HALL_YLW_RISE: begin
        if (yb >= 0) raw_torque = yb - back_emf;
        else if (bg < 0) raw_torque = bg + back_emf;
      end
      HALL_YLW_2ND: raw_torque = (gy <= 0) ? -gy - back_emf : -gy + back_emf;
      HALL_BLU_RISE: begin
        if (bg >= 0) raw_torque = bg - back_emf;
        else if (yb < 0) raw_torque = yb + back_emf;
      end
      HALL_BLU_2ND: begin
        if (yb <= 0) raw_torque = -yb - back_emf;
        else if (bg > 0) raw_torque = -bg + back_emf;
      end
      default: raw_torque = '0;  // illegal hall, no drive
    endcase
  end

  ////////////////////
  // friction
  ////////////////////

  always_comb begin
    if (raw_torque > FRICTION_T) net_torque = raw_torque - FRICTION_T;
    else if (raw_torque < -FRICTION_T) net_torque = raw_torque + FRICTION_T;
    else if (omega > DEADBAND) net_torque = -FRICTION_T;  // coasting forward
    else if (omega < -DEADBAND) net_torque = FRICTION_T;  // coasting back
    else net_torque = '0;  // stalled
  end

  assign alpha = net_torque >>> 1;  // inertia scaling

endmodule

//--- rotor_integrator.sv
`timescale 1ns/100ps
`include "hub_motor_settings.svh"

module rotor_integrator (
  input  logic               clk,
  input  logic               RST_n,
  input  logic               period_vld,
  input  rotor_pkg::torque_t alpha,
  output rotor_pkg::omega_t  omega,
  output rotor_pkg::hall_t   hall
);

  import rotor_pkg::*;

  localparam theta_t THETA_FULL_T = `THETA_FULL;
  localparam theta_t THETA_INIT   = `THETA_RESET;

  theta_t             theta;      // angle, deg * 64
  logic signed [15:0] new_theta;  // unwrapped next angle
  logic [8:0]         pos;        // angle in whole degrees

  ////////////////////
  // integrators
  ////////////////////

  assign new_theta = $signed({1'b0, theta}) + $signed(16'(omega >>> 8));

  always_ff @(posedge clk, negedge RST_n) begin
    if (!RST_n) begin
      omega <= '0;
      theta <= THETA_INIT;  // mid green rise sector
    end else if (period_vld) begin
      omega <= omega + omega_t'(alpha >>> 2);
      if (new_theta < 0) begin
        theta <= new_theta[14:0] + THETA_FULL_T;  // wrap below zero
      end else if (new_theta >= $signed({1'b0, THETA_FULL_T})) begin
        theta <= new_theta[14:0] - THETA_FULL_T;  // wrap past 360
      end else begin
        theta <= new_theta[14:0];
      end
    end
  end

  ////////////////////
  // hall decode
  ////////////////////

  assign pos = theta[14:6];

  // six 60 deg sectors
  always_comb begin
    if (pos < 9'd60) hall = HALL_GRN_RISE;
    else if (pos < 9'd120) hall = HALL_GRN_2ND;
    else if (pos < 9'd180) hall = HALL_YLW_RISE;
    else if (pos < 9'd240) hall = HALL_YLW_2ND;
    else if (pos < 9'd300) hall = HALL_BLU_RISE;
    else hall = HALL_BLU_2ND;  // theta always below 360 deg
  end

endmodule

//--- current_filter.sv
`timescale 1ns/100ps

module current_filter (
  input  logic                 clk,
  input  logic                 RST_n,
  input  logic                 period_vld,
  input  motor_pkg::coil_set_t coil,
  input  rotor_pkg::omega_t    omega,
  output motor_pkg::curr_t     avg_curr
);

  import motor_pkg::*;
  import rotor_pkg::*;

  function automatic logic [11:0] mag(input coil_v_t v);
    return v[12] ? 12'(-v) : 12'(v);
  endfunction

  omega_t      omega_abs;     // speed magnitude
  logic [13:0] sum_coil_v;    // total coil voltage magnitude
  logic [11:0] speed_factor;  // 512 is unity
  logic [25:0] scaled;
  logic [16:0] curr_term;     // new sample
  logic [21:0] accum;         // 32x the average
  logic [26:0] accum_x31;

  assign omega_abs    = omega[19] ? -omega : omega;
  assign sum_coil_v   = mag(coil.gy) + mag(coil.yb) + mag(coil.bg);
  assign speed_factor = 12'h200 + omega_abs[18:8];  // 1 + |omega|/2^17
  assign scaled       = sum_coil_v * speed_factor;
  assign curr_term    = scaled[25:9];
  assign accum_x31    = accum * 5'd31;

  // first order lowpass, one step per pwm period
  always_ff @(posedge clk, negedge RST_n) begin
    if (!RST_n) begin
      accum <= '0;
    end else if (period_vld) begin
      accum <= accum_x31[26:5] + curr_term;
    end
  end

  // clamp at full scale rather than wrap at high speed
  assign avg_curr = (|accum[21:17]) ? 12'hFFF : accum[16:5];

endmodule

//--- hub_motor_model.sv
`timescale 1ns/100ps

module hub_motor_model (
  input  logic             clk,
  input  logic             RST_n,
  input  logic             high_grn,  // green coil fets
  input  logic             low_grn,
  input  logic             high_ylw,  // yellow coil fets
  input  logic             low_ylw,
  input  logic             high_blu,  // blue coil fets
  input  logic             low_blu,
  output logic             hall_grn,
  output logic             hall_ylw,
  output logic             hall_blu,
  output motor_pkg::curr_t avg_curr
);

  import motor_pkg::*;
  import rotor_pkg::*;

  gate_drive_t gates;
  duty_set_t   duty;
  logic        period_vld;  // one clk pulse after each period end
  coil_set_t   coil;
  torque_t     alpha;
  omega_t      omega;
  hall_t       hall;

  assign gates = '{high_grn: high_grn, low_grn: low_grn,
                   high_ylw: high_ylw, low_ylw: low_ylw,
                   high_blu: high_blu, low_blu: low_blu};

  ////////////////////
  // electrical
  ////////////////////

  duty_capture duty_capture_i (
    .clk        (clk),
    .RST_n      (RST_n),
    .gates      (gates),
    .duty       (duty),
    .period_vld (period_vld)
  );

  coil_voltage coil_voltage_i (.duty(duty), .coil(coil));

  ////////////////////
  // mechanical
  ////////////////////

  torque_model torque_model_i (.coil(coil), .hall(hall), .omega(omega), .alpha(alpha));

  rotor_integrator rotor_integrator_i (
    .clk        (clk),
    .RST_n      (RST_n),
    .period_vld (period_vld),
    .alpha      (alpha),
    .omega      (omega),
    .hall       (hall)
  );

  current_filter current_filter_i (
    .clk        (clk),
    .RST_n      (RST_n),
    .period_vld (period_vld),
    .coil       (coil),
    .omega      (omega),
    .avg_curr   (avg_curr)
  );

  assign hall_grn = hall.grn;
  assign hall_ylw = hall.ylw;
  assign hall_blu = hall.blu;

endmodule

//--- hub_motor_model_chk.sv
`timescale 1ns/100ps

module hub_motor_model_chk (
  input logic             clk,
  input logic             RST_n,
  input logic             period_vld,
  input rotor_pkg::hall_t hall
);

  import rotor_pkg::*;

  // sector after h in forward rotation
  function automatic hall_t step_fwd(input hall_t h);
    case (h)
      HALL_GRN_RISE: return HALL_GRN_2ND;
      HALL_GRN_2ND:  return HALL_YLW_RISE;
      HALL_YLW_RISE: return HALL_YLW_2ND;
      HALL_YLW_2ND:  return HALL_BLU_RISE;
      HALL_BLU_RISE: return HALL_BLU_2ND;
      HALL_BLU_2ND:  return HALL_GRN_RISE;
      default:       return 3'b000;
    endcase
  endfunction

  ////////////////////
  // hall properties
  ////////////////////

  a_hall_legal: assert property (@(posedge clk) disable iff (!RST_n)
    (hall != 3'b000) && (hall != 3'b111))
    else $error("hall state %b is illegal", hall);

  // one sector per step, either direction
  a_hall_adjacent: assert property (@(posedge clk) disable iff (!RST_n)
    (hall != $past(hall)) |-> (hall == step_fwd($past(hall)) || $past(hall) == step_fwd(hall)))
    else $error("hall skipped a sector, now %b", hall);

  a_hall_timing: assert property (@(posedge clk) disable iff (!RST_n)
    (hall != $past(hall)) |-> $past(period_vld))  // theta only moves on the strobe
    else $error("hall changed outside the period update");

endmodule

//--- hub_motor_model_tb.sv
`timescale 1ns/100ps
`include "hub_motor_settings.svh"

module hub_motor_model_tb;

  import motor_pkg::*;
  import rotor_pkg::*;

  localparam int PERIOD_CLKS = 1 << `PWM_BITS;        // clk per pwm period
  localparam int FIRST_UPD   = PERIOD_CLKS + 1;       // first output update after release
  localparam int VLD_TIMEOUT = 2 * PERIOD_CLKS + 16;  // max clk to the next period strobe
  localparam gate_drive_t GATES_OFF = 6'b000000;
  localparam gate_drive_t GATES_FWD = 6'b100100;      // high_grn and low_ylw give gy = +4094
  localparam gate_drive_t GATES_REV = 6'b011000;      // low_grn and high_ylw give gy = -4094
  localparam hall_t HALL_RESET = 3'b101;              // reset angle sits in green rise
  localparam hall_t FWD_ORDER [6] = '{3'b101, 3'b100, 3'b110, 3'b010, 3'b011, 3'b001};

  typedef enum int {ROT_NONE, ROT_FWD, ROT_REV} rot_e;

  typedef struct {
    string       name;
    logic        do_reset;  // reset before the row with gates applied at release
    gate_drive_t gates;
    int          periods;   // pwm periods to run
    rot_e        rot;       // expected rotation
  } test_row_t;

  logic clk, RST_n;
  logic high_grn, low_grn, high_ylw, low_ylw, high_blu, low_blu;
  logic hall_grn, hall_ylw, hall_blu;
  curr_t avg_curr;
  hall_t hall_now;          // hall ports as one value
  test_row_t tests [4];
  int err_cnt, pass_cnt, fail_cnt;
  int edges;                // rising edges since reset release
  hall_t mon_hall;
  curr_t mon_curr;

  assign hall_now = {hall_grn, hall_ylw, hall_blu};

  hub_motor_model dut_i (
    .clk(clk), .RST_n(RST_n),
    .high_grn(high_grn), .low_grn(low_grn), .high_ylw(high_ylw),
    .low_ylw(low_ylw), .high_blu(high_blu), .low_blu(low_blu),
    .hall_grn(hall_grn), .hall_ylw(hall_ylw), .hall_blu(hall_blu),
    .avg_curr(avg_curr)
  );

  bind rotor_integrator hub_motor_model_chk chk_i (
    .clk(clk), .RST_n(RST_n), .period_vld(period_vld), .hall(hall)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic hall_t next_hall(input hall_t h);
    for (int i = 0; i < 6; i++) begin
      if (FWD_ORDER[i] == h) return FWD_ORDER[(i + 1) % 6];
    end
    return 3'b000;  // no successor for an illegal state
  endfunction

  function automatic hall_t prev_hall(input hall_t h);
    for (int i = 0; i < 6; i++) begin
      if (FWD_ORDER[i] == h) return FWD_ORDER[(i + 5) % 6];
    end
    return 3'b000;
  endfunction

  task automatic drive_gates(input gate_drive_t g);
    {high_grn, low_grn, high_ylw, low_ylw, high_blu, low_blu} = g;
  endtask

  task automatic log_error(input string name, input string what);
    $display("Error in %s: %s", name, what);
    err_cnt++;
  endtask

  task automatic check_hall(input string name, input hall_t exp, input hall_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: hall expected %b, actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_curr(input string name, input curr_t exp, input curr_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: avg_curr expected %0d, actual %0d", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic reset_dut(input gate_drive_t g);
    RST_n = 1'b0;
    drive_gates(GATES_OFF);
    repeat (8) @(posedge clk);
    #1;
    drive_gates(g);  // first period after release is a full one
    RST_n = 1'b1;
  endtask

  // returns 1 ns after the edge that raised period_vld
  task automatic wait_period_vld;
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < VLD_TIMEOUT && !seen; n++) begin
      @(posedge clk);
      #1;
      seen = dut_i.period_vld;
    end
    if (!seen) begin
      $display("Timeout: no period strobe within %0d clk cycles", VLD_TIMEOUT);
      $display("Test failed");
      $finish;
    end
  endtask

  ////////////////////
  // one table row
  ////////////////////

  task automatic run_row(input int idx);
    int errs_before;
    int steps;        // hall steps in the expected direction
    hall_t start_hall, prev_h, exp_h;
    curr_t prev_c;
    errs_before = err_cnt;
    steps = 0;
    if (tests[idx].do_reset) begin
      reset_dut(tests[idx].gates);
      check_hall(tests[idx].name, HALL_RESET, hall_now);  // reset values
      check_curr(tests[idx].name, '0, avg_curr);
    end else begin
      wait_period_vld();
      drive_gates(tests[idx].gates);  // aligned to the period start
      @(posedge clk);
      #1;
    end
    start_hall = hall_now;
    prev_h = hall_now;
    prev_c = avg_curr;
    for (int p = 0; p < tests[idx].periods; p++) begin
      wait_period_vld();
      @(posedge clk);  // rotor and filter step on this edge
      #1;
      if (tests[idx].rot == ROT_NONE) begin
        check_hall(tests[idx].name, HALL_RESET, hall_now);
        check_curr(tests[idx].name, '0, avg_curr);
      end else begin
        if (hall_now != prev_h) begin
          exp_h = (tests[idx].rot == ROT_FWD) ? next_hall(prev_h) : prev_hall(prev_h);
          check_hall(tests[idx].name, exp_h, hall_now);
          steps++;
        end
        // speed still rising in the driven sector
        if (prev_h == start_hall && avg_curr < prev_c)
          log_error(tests[idx].name,
                    $sformatf("avg_curr fell from %0d to %0d", prev_c, avg_curr));
      end
      prev_h = hall_now;
      prev_c = avg_curr;
    end
    if (tests[idx].rot != ROT_NONE) begin
      if (steps == 0) log_error(tests[idx].name, "rotor never left its start sector");
      if (avg_curr == '0) log_error(tests[idx].name, "avg_curr stayed at zero under drive");
    end
    if (err_cnt == errs_before) pass_cnt++;
    else fail_cnt++;
    $display("%-14s %s  hall %b  avg_curr %0d  errors %0d", tests[idx].name,
             (err_cnt == errs_before) ? "ok  " : "FAIL", hall_now, avg_curr,
             err_cnt - errs_before);
  endtask

  ////////////////////
  // output update timing
  ////////////////////

  always @(posedge clk) edges = RST_n ? edges + 1 : 0;

  always @(negedge clk) begin
    if (RST_n && (hall_now !== mon_hall || avg_curr !== mon_curr)) begin
      if (edges < FIRST_UPD || (edges - FIRST_UPD) % PERIOD_CLKS != 0) begin
        $display("Error: outputs changed %0d clk after reset release, off the update slot",
                 edges);
        err_cnt++;
      end
    end
    mon_hall = hall_now;
    mon_curr = avg_curr;
  end

  initial begin
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    edges = 0;
    mon_hall = 3'b101;
    mon_curr = '0;
    RST_n = 1'b0;
    drive_gates(GATES_OFF);
    tests[0] = '{"reset_state", 1'b1, GATES_OFF, 0, ROT_NONE};
    tests[1] = '{"idle_hold", 1'b0, GATES_OFF, 4, ROT_NONE};
    tests[2] = '{"forward_drive", 1'b0, GATES_FWD, 100, ROT_FWD};
    tests[3] = '{"reverse_drive", 1'b1, GATES_REV, 100, ROT_REV};
    for (int i = 0; i < 4; i++) run_row(i);
    $display("%0d tests: %0d passed, %0d failed, %0d errors", 4, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hub_motor_model.f
+incdir+.
motor_pkg.sv
rotor_pkg.sv
duty_capture.sv
coil_voltage.sv
torque_model.sv
rotor_integrator.sv
current_filter.sv
hub_motor_model.sv
hub_motor_model_chk.sv
hub_motor_model_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the hub motor testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f hub_motor_model.f \
  --top-module hub_motor_model_tb -o hub_motor_model_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/hub_motor_model_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
